// ==== sources.f ====
src/snake_pkg.sv
src/vga_timing.sv
src/snake_regs.sv
src/sprite_ram.sv
src/tile_select.sv
src/pixel_out.sv
src/vga_snake_top.sv
tb/vga_snake_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the VGA snake testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module vga_snake_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vvga_snake_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
fi
exit 1

// ==== tb/vga_snake_tb.sv ====
`timescale 1ns/1ps

module vga_snake_tb;
  import snake_pkg::*;

  localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
  localparam int HS_START     = int'(H_ACTIVE) + int'(H_FRONT);
  localparam int HS_END       = HS_START + int'(H_SYNC);
  localparam int VS_START     = int'(V_ACTIVE) + int'(V_FRONT);
  localparam int VS_END       = VS_START + int'(V_SYNC);
  // six frames plus the reset period
  localparam int WATCHDOG_CYCLES = 16 + 6 * FRAME_CYCLES;
  // sync outputs inactive and blanked while in reset
  localparam sync_t RESET_SYNC = '{hs: 1'b1, vs: 1'b1, blank_n: 1'b0, pix_clk: 1'b0};

  logic       clk;
  logic       reset;
  logic       write;
  logic       chipselect;
  bus_addr_t  address;
  bus_data_t  writedata;
  logic [7:0] vga_r;
  logic [7:0] vga_g;
  logic [7:0] vga_b;
  logic       vga_clk;
  logic       vga_hs;
  logic       vga_vs;
  logic       vga_blank_n;
  logic       vga_sync_n;

  // m_h and m_v follow the DUT counters
  // ph and pv hold the pixel now on the outputs
  int         m_h;
  int         m_v;
  int         ph [3];
  int         pv [3];
  logic [2:0] pok;

  // host side copy of everything written to the DUT
  scene_t      scene_model;
  pixel_word_u bg_model;
  logic [15:0] sprite_model [0:NUM_SPRITES*SPRITE_WORDS-1];

  logic [15:0] lfsr;
  int          n_checks;
  int          n_errors;
  int          start_errors;
  string       cur_test;

  vga_snake_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .write       (write),
    .chipselect  (chipselect),
    .address     (address),
    .writedata   (writedata),
    .VGA_R       (vga_r),
    .VGA_G       (vga_g),
    .VGA_B       (vga_b),
    .VGA_CLK     (vga_clk),
    .VGA_HS      (vga_hs),
    .VGA_VS      (vga_vs),
    .VGA_BLANK_n (vga_blank_n),
    .VGA_SYNC_n  (vga_sync_n)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------------------------
  // beam model three cycles ahead of the outputs
  // ----------------------------------------------------------
  always @(posedge clk) begin
    if (reset) begin
      m_h <= 0;
      m_v <= 0;
      pok <= '0;
    end else begin
      ph[0] <= m_h;
      pv[0] <= m_v;
      ph[1] <= ph[0];
      pv[1] <= pv[0];
      ph[2] <= ph[1];
      pv[2] <= pv[1];
      pok   <= {pok[1:0], 1'b1};
      if (m_h == int'(H_TOTAL) - 1) begin
        m_h <= 0;
        m_v <= (m_v == int'(V_TOTAL) - 1) ? 0 : m_v + 1;
      end else begin
        m_h <= m_h + 1;
      end
    end
  end

  // no pixel wait may outlast six frames
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the VGA outputs never reached the awaited pixel");
    $display("test failed");
    $finish;
  end

  // ----------------------------------------------------------
  // 16 bit fibonacci lfsr for random data
  // ----------------------------------------------------------
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    // taps 16 14 13 11
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit
  task automatic random_bits(input int n, output bus_data_t v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = next_lfsr(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // ----------------------------------------------------------
  // expected values from the display rules
  // ----------------------------------------------------------
  function automatic sync_t expect_sync(input int h, input int v);
    sync_t s;
    s.hs      = !(h >= HS_START && h < HS_END);
    s.vs      = !(v >= VS_START && v < VS_END);
    s.blank_n = h < int'(H_ACTIVE) && v < int'(V_ACTIVE);
    s.pix_clk = (h % 2) == 1;
    return s;
  endfunction

  function automatic rgb565_t expect_colour(input int h, input int v);
    int          col;
    int          cx;
    int          cy;
    int          off;
    pixel_word_u w;
    col = h / 2;
    cx  = col / CELL_PIX;
    cy  = v / CELL_PIX;
    off = (v % CELL_PIX) * CELL_PIX + col % CELL_PIX;
    // apple over head over wall over background
    if (h >= int'(H_ACTIVE) || v >= int'(V_ACTIVE)) begin
      w.raw = '0;
    end else if (scene_model.apple_on && cx == int'(scene_model.apple.col) &&
                 cy == int'(scene_model.apple.row)) begin
      w.raw = sprite_model[int'(SPR_APPLE) * SPRITE_WORDS + off];
    end else if (scene_model.head_on && cx == int'(scene_model.head.col) &&
                 cy == int'(scene_model.head.row)) begin
      w.raw = sprite_model[int'(SPR_HEAD) * SPRITE_WORDS + off];
    end else if (cx == 0 || cx == GRID_COLS - 1 || cy == 0 || cy == GRID_ROWS - 1) begin
      w.raw = sprite_model[int'(SPR_WALL) * SPRITE_WORDS + off];
    end else begin
      w = bg_model;
    end
    return w.rgb;
  endfunction

  function automatic sync_t dut_sync();
    sync_t s;
    s.hs      = vga_hs;
    s.vs      = vga_vs;
    s.blank_n = vga_blank_n;
    s.pix_clk = vga_clk;
    return s;
  endfunction

  // ----------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------
  task automatic check_rgb(input rgb565_t exp, input logic [7:0] r, g, b);
    logic [23:0] exp_px;
    exp_px = {exp.r, 3'b000, exp.g, 2'b00, exp.b, 3'b000};
    n_checks++;
    if ({r, g, b} !== exp_px) begin
      n_errors++;
      $display("FAIL %s expected rgb %06h actual %06h", cur_test, exp_px, {r, g, b});
    end
  endtask

  task automatic check_sync(input sync_t exp, input sync_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAIL %s expected hs,vs,blank_n,clk %b actual %b", cur_test, exp, act);
    end
  endtask

  task automatic check_count(input int exp, input int act);
    n_checks++;
    if (act != exp) begin
      n_errors++;
      $display("FAIL %s expected count %0d actual %0d", cur_test, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    start_errors = n_errors;
  endtask

  task automatic end_test();
    $display("%s finished with %0d errors", cur_test, n_errors - start_errors);
  endtask

  // ----------------------------------------------------------
  // host port and beam waits
  // ----------------------------------------------------------
  task automatic host_write(input bus_addr_t a, input bus_data_t d);
    @(posedge clk);
    address    <= a;
    writedata  <= d;
    write      <= 1'b1;
    chipselect <= 1'b1;
    @(posedge clk);
    write      <= 1'b0;
    chipselect <= 1'b0;
  endtask

  task automatic set_background(input logic [15:0] w);
    host_write(REG_BACKGROUND, {16'h0000, w});
    bg_model.raw = w;
  endtask

  // col in bits 5:0 and row in bits 20:16
  task automatic set_cell(input bus_addr_t a, input cell_pos_t pos);
    bus_data_t d;
    d = '0;
    d[5:0]   = pos.col;
    d[20:16] = pos.row;
    host_write(a, d);
    if (a == REG_APPLE) begin
      scene_model.apple = pos;
    end else begin
      scene_model.head = pos;
    end
  endtask

  task automatic set_control(input logic apple_on, input logic head_on);
    host_write(REG_CONTROL, {30'd0, head_on, apple_on});
    scene_model.apple_on = apple_on;
    scene_model.head_on  = head_on;
  endtask

  task automatic load_sprite(input int idx);
    int        i;
    bus_data_t d;
    for (i = 0; i < SPRITE_WORDS; i++) begin
      random_bits(16, d);
      sprite_model[idx * SPRITE_WORDS + i] = d[15:0];
      host_write(SPRITE_BASE + bus_addr_t'(idx * SPRITE_WORDS + i), d);
    end
  endtask

  // outputs settle after the rising edge so sample on the falling one
  task automatic wait_pixel(input int col, input int row);
    do begin
      @(negedge clk);
    end while (!(pok[2] && ph[2] == 2 * col && pv[2] == row));
  endtask

  task automatic check_pixel(input int col, input int row);
    wait_pixel(col, row);
    check_rgb(expect_colour(ph[2], pv[2]), vga_r, vga_g, vga_b);
  endtask

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic reset_sync_test();
    int i;
    int hs_low;
    int vs_low;
    start_test("reset_sync");
    hs_low = 0;
    vs_low = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_sync(RESET_SYNC, dut_sync());
    check_rgb('0, vga_r, vga_g, vga_b);
    n_checks++;
    if (vga_sync_n !== 1'b0) begin
      n_errors++;
      $display("FAIL %s expected VGA_SYNC_n 0 actual %b", cur_test, vga_sync_n);
    end
    @(posedge clk);
    reset <= 1'b0;
    // one whole frame from the first valid output pixel
    wait_pixel(0, 0);
    for (i = 0; i < FRAME_CYCLES; i++) begin
      check_sync(expect_sync(ph[2], pv[2]), dut_sync());
      if (pv[2] == 0 && !vga_hs) begin
        hs_low++;
      end
      if (ph[2] == 0 && !vga_vs) begin
        vs_low++;
      end
      @(negedge clk);
    end
    check_count(int'(H_SYNC), hs_low);
    check_count(int'(V_SYNC), vs_low);
    end_test();
  endtask

  task automatic background_test();
    bus_data_t d;
    start_test("background");
    random_bits(16, d);
    set_background(d[15:0]);
    check_pixel(200, 200);
    check_pixel(333, 250);
    end_test();
  endtask

  task automatic wall_test();
    start_test("wall");
    load_sprite(int'(SPR_WALL));
    check_pixel(100, 5);
    check_pixel(3, 100);
    check_pixel(630, 300);
    check_pixel(300, 470);
    end_test();
  endtask

  task automatic sprite_test();
    start_test("apple_head");
    load_sprite(int'(SPR_APPLE));
    load_sprite(int'(SPR_HEAD));
    set_cell(REG_APPLE, cell_pos_t'{col: 6'd5, row: 5'd5});
    set_cell(REG_HEAD, cell_pos_t'{col: 6'd10, row: 5'd8});
    set_control(1'b1, 1'b1);
    check_pixel(83, 87);
    check_pixel(94, 90);
    check_pixel(170, 130);
    check_pixel(161, 141);
    // apple onto the left wall
    set_cell(REG_APPLE, cell_pos_t'{col: 6'd0, row: 5'd20});
    check_pixel(9, 327);
    end_test();
  endtask

  task automatic control_test();
    start_test("control");
    set_control(1'b1, 1'b0);
    check_pixel(170, 130);
    check_pixel(9, 327);
    end_test();
  endtask

  task automatic blanking_test();
    bus_data_t d;
    start_test("blanking");
    random_bits(16, d);
    set_background(d[15:0] | 16'h8421);
    check_pixel(700, 400);
    check_pixel(100, 500);
    check_pixel(650, 515);
    end_test();
  endtask

  initial begin
    reset       = 1'b1;
    write       = 1'b0;
    chipselect  = 1'b0;
    address     = '0;
    writedata   = '0;
    lfsr        = 16'd51375;
    n_checks    = 0;
    n_errors    = 0;
    scene_model = '0;
    bg_model    = '0;
    reset_sync_test();
    background_test();
    wall_test();
    sprite_test();
    control_test();
    blanking_test();
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== src/vga_snake_top.sv ====
`timescale 1ns/1ps

module vga_snake_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 write,
  input  logic                 chipselect,
  input  snake_pkg::bus_addr_t address,
  input  snake_pkg::bus_data_t writedata,
  output logic [7:0]           VGA_R,
  output logic [7:0]           VGA_G,
  output logic [7:0]           VGA_B,
  output logic                 VGA_CLK,
  output logic                 VGA_HS,
  output logic                 VGA_VS,
  output logic                 VGA_BLANK_n,
  output logic                 VGA_SYNC_n
);
  import snake_pkg::*;

  // ----------------------------------------------------------
  // internal nets
  // ----------------------------------------------------------
  hcount_t      hcount;
  vcount_t      vcount;
  sync_t        beam_sync;
  sync_t        tile_sync;
  scene_t       scene;
  pixel_word_u  background;
  logic         spr_we;
  sprite_addr_t spr_waddr;
  pixel_word_u  spr_wdata;
  sprite_addr_t spr_raddr;
  pixel_word_u  spr_rdata;
  layer_t       layer;

  // sync on green not used
  assign VGA_SYNC_n = 1'b0;

  // beam counters
  vga_timing timing_i (
    .clk    (clk),
    .reset  (reset),
    .hcount (hcount),
    .vcount (vcount),
    .sync   (beam_sync)
  );

  // host write port
  snake_regs regs_i (
    .clk        (clk),
    .reset      (reset),
    .address    (address),
    .writedata  (writedata),
    .write      (write),
    .chipselect (chipselect),
    .scene      (scene),
    .background (background),
    .spr_we     (spr_we),
    .spr_waddr  (spr_waddr),
    .spr_wdata  (spr_wdata)
  );

  sprite_ram ram_i (
    .clk   (clk),
    .we    (spr_we),
    .waddr (spr_waddr),
    .wdata (spr_wdata),
    .raddr (spr_raddr),
    .rdata (spr_rdata)
  );

  tile_select tile_i (
    .clk       (clk),
    .reset     (reset),
    .hcount    (hcount),
    .vcount    (vcount),
    .sync_in   (beam_sync),
    .scene     (scene),
    .spr_raddr (spr_raddr),
    .layer     (layer),
    .sync_out  (tile_sync)
  );

  pixel_out pixel_i (
    .clk         (clk),
    .reset       (reset),
    .layer       (layer),
    .sync_in     (tile_sync),
    .sprite_pix  (spr_rdata),
    .background  (background),
    .vga_r       (VGA_R),
    .vga_g       (VGA_G),
    .vga_b       (VGA_B),
    .vga_hs      (VGA_HS),
    .vga_vs      (VGA_VS),
    .vga_blank_n (VGA_BLANK_n),
    .vga_clk     (VGA_CLK)
  );

endmodule

// ==== src/pixel_out.sv ====
`timescale 1ns/1ps

module pixel_out (
  input  logic                   clk,
  input  logic                   reset,
  input  snake_pkg::layer_t      layer,
  input  snake_pkg::sync_t       sync_in,
  input  snake_pkg::pixel_word_u sprite_pix,
  input  snake_pkg::pixel_word_u background,
  output logic [7:0]             vga_r,
  output logic [7:0]             vga_g,
  output logic [7:0]             vga_b,
  output logic                   vga_hs,
  output logic                   vga_vs,
  output logic                   vga_blank_n,
  output logic                   vga_clk
);
  import snake_pkg::*;

  layer_t      layer_q;
  sync_t       sync_q;
  pixel_word_u word;

  // ----------------------------------------------------------
  // wait one stage for the sprite RAM data
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      layer_q <= LAYER_BG;
      sync_q  <= SYNC_IDLE;
    end else begin
      layer_q <= layer;
      sync_q  <= sync_in;
    end
  end

  // background word or sprite word
  always_comb begin
    word = (layer_q == LAYER_BG) ? background : sprite_pix;
    // black outside the active area
    if (!sync_q.blank_n) begin
      word = '0;
    end
  end

  // ----------------------------------------------------------
  // output register, rgb565 padded with zeros
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vga_r       <= '0;
      vga_g       <= '0;
      vga_b       <= '0;
      vga_hs      <= 1'b1;
      vga_vs      <= 1'b1;
      vga_blank_n <= 1'b0;
      vga_clk     <= 1'b0;
    end else begin
      vga_r       <= {word.rgb.r, 3'b000};
      vga_g       <= {word.rgb.g, 2'b00};
      vga_b       <= {word.rgb.b, 3'b000};
      vga_hs      <= sync_q.hs;
      vga_vs      <= sync_q.vs;
      vga_blank_n <= sync_q.blank_n;
      vga_clk     <= sync_q.pix_clk;
    end
  end

endmodule

// ==== src/tile_select.sv ====
`timescale 1ns/1ps

module tile_select (
  input  logic                    clk,
  input  logic                    reset,
  input  snake_pkg::hcount_t      hcount,
  input  snake_pkg::vcount_t      vcount,
  input  snake_pkg::sync_t        sync_in,
  input  snake_pkg::scene_t       scene,
  output snake_pkg::sprite_addr_t spr_raddr,
  output snake_pkg::layer_t       layer,
  output snake_pkg::sync_t        sync_out
);
  import snake_pkg::*;

  logic [5:0] cell_col;
  logic [5:0] cell_row;
  logic [3:0] off_col;
  logic [3:0] off_row;
  logic       hit_apple;
  logic       hit_head;
  logic       on_border;
  layer_t     next_layer;
  logic [1:0] next_idx;

  // ----------------------------------------------------------
  // beam to cell
  // ----------------------------------------------------------
  // pixel column is hcount/2 so the cell is hcount/32
  assign cell_col = hcount[10:5];
  assign off_col  = hcount[4:1];
  assign cell_row = vcount[9:4];
  assign off_row  = vcount[3:0];

  // row extended so lines past 511 never alias row 0
  assign hit_apple = scene.apple_on && cell_col == scene.apple.col &&
                     cell_row == {1'b0, scene.apple.row};
  assign hit_head  = scene.head_on && cell_col == scene.head.col &&
                     cell_row == {1'b0, scene.head.row};
  assign on_border = cell_col == 6'd0 || cell_col == 6'(GRID_COLS - 1) ||
                     cell_row == 6'd0 || cell_row == 6'(GRID_ROWS - 1);

  // ----------------------------------------------------------
  // layer priority
  // ----------------------------------------------------------
  always_comb begin
    next_layer = LAYER_BG;
    next_idx   = SPR_WALL;
    if (hit_apple) begin
      next_layer = LAYER_APPLE;
      next_idx   = SPR_APPLE;
    end else if (hit_head) begin
      next_layer = LAYER_HEAD;
      next_idx   = SPR_HEAD;
    end else if (on_border) begin
      next_layer = LAYER_WALL;
    end
  end

  // layer and sync stay paired through the pipe
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      layer    <= LAYER_BG;
      sync_out <= SYNC_IDLE;
    end else begin
      layer    <= next_layer;
      sync_out <= sync_in;
    end
  end

  // sprite index, row offset, column offset
  always_ff @(posedge clk) begin
    spr_raddr <= {next_idx, off_row, off_col};
  end

  // wall only ever drawn on the border ring of the raw beam
  assert property (@(posedge clk) disable iff (reset)
    layer == LAYER_WALL |->
      $past(int'(hcount) < 2 * CELL_PIX ||
            (int'(hcount) >= 2 * CELL_PIX * (GRID_COLS - 1) && hcount < H_ACTIVE) ||
            int'(vcount) < CELL_PIX ||
            (int'(vcount) >= CELL_PIX * (GRID_ROWS - 1) && vcount < V_ACTIVE)));

endmodule

// ==== src/sprite_ram.sv ====
`timescale 1ns/1ps

module sprite_ram (
  input  logic                    clk,
  input  logic                    we,
  input  snake_pkg::sprite_addr_t waddr,
  input  snake_pkg::pixel_word_u  wdata,
  input  snake_pkg::sprite_addr_t raddr,
  output snake_pkg::pixel_word_u  rdata
);
  import snake_pkg::*;

  // apple, head and wall back to back
  pixel_word_u mem [0:NUM_SPRITES*SPRITE_WORDS-1];

  // host side
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // beam side, one cycle read
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

// ==== src/snake_regs.sv ====
`timescale 1ns/1ps

module snake_regs (
  input  logic                    clk,
  input  logic                    reset,
  input  snake_pkg::bus_addr_t    address,
  input  snake_pkg::bus_data_t    writedata,
  input  logic                    write,
  input  logic                    chipselect,
  output snake_pkg::scene_t       scene,
  output snake_pkg::pixel_word_u  background,
  output logic                    spr_we,
  output snake_pkg::sprite_addr_t spr_waddr,
  output snake_pkg::pixel_word_u  spr_wdata
);
  import snake_pkg::*;

  logic      wr_en;
  bus_addr_t spr_off;
  logic      in_sprite_win;

  // one write per edge with chipselect and write high
  assign wr_en = chipselect && write;

  // offset into the sprite window
  assign spr_off       = address - SPRITE_BASE;
  assign in_sprite_win = (address >= SPRITE_BASE) &&
                         (spr_off < bus_addr_t'(NUM_SPRITES * SPRITE_WORDS));

  // ----------------------------------------------------------
  // control registers
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      scene      <= '0;
      background <= '0;
    end else if (wr_en) begin
      case (address)
        REG_BACKGROUND: background.raw <= writedata[15:0];
        // col in low half, row in high half
        REG_APPLE:      scene.apple <= '{col: writedata[5:0], row: writedata[20:16]};
        REG_HEAD:       scene.head  <= '{col: writedata[5:0], row: writedata[20:16]};
        REG_CONTROL: begin
          scene.apple_on <= writedata[0];
          scene.head_on  <= writedata[1];
        end
        default: ;
      endcase
    end
  end

  // sprite write request, one cycle behind the bus
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      spr_we <= 1'b0;
    end else begin
      spr_we <= wr_en && in_sprite_win;
    end
  end

  always_ff @(posedge clk) begin
    spr_waddr     <= spr_off[9:0];
    spr_wdata.raw <= writedata[15:0];
  end

  // decoded sprite writes never leave the loaded sprites
  assert property (@(posedge clk) disable iff (reset)
    spr_we |-> spr_waddr < sprite_addr_t'(NUM_SPRITES * SPRITE_WORDS));

endmodule

// ==== src/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing (
  input  logic               clk,
  input  logic               reset,
  output snake_pkg::hcount_t hcount,
  output snake_pkg::vcount_t vcount,
  output snake_pkg::sync_t   sync
);
  import snake_pkg::*;

  logic end_of_line;
  logic end_of_frame;
  logic in_hsync;
  logic in_vsync;

  assign end_of_line  = hcount == H_TOTAL - 11'd1;
  assign end_of_frame = vcount == V_TOTAL - 10'd1;

  // ----------------------------------------------------------
  // line counter
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hcount <= '0;
    end else if (end_of_line) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + 11'd1;
    end
  end

  // frame counter, steps once per line
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vcount <= '0;
    end else if (end_of_line) begin
      if (end_of_frame) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 10'd1;
      end
    end
  end

  // ----------------------------------------------------------
  // sync windows after the front porch
  // ----------------------------------------------------------
  assign in_hsync = (hcount >= H_ACTIVE + H_FRONT) &&
                    (hcount <  H_ACTIVE + H_FRONT + H_SYNC);
  assign in_vsync = (vcount >= V_ACTIVE + V_FRONT) &&
                    (vcount <  V_ACTIVE + V_FRONT + V_SYNC);

  assign sync.hs      = !in_hsync;
  assign sync.vs      = !in_vsync;
  assign sync.blank_n = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);
  // pixel clock at half rate, rises mid pixel
  assign sync.pix_clk = hcount[0];

  // counters stay inside the frame
  assert property (@(posedge clk) disable iff (reset)
    hcount < H_TOTAL && vcount < V_TOTAL);

endmodule

// ==== src/snake_pkg.sv ====
package snake_pkg;

  // ----------------------------------------------------------
  // basic bus and beam types
  // ----------------------------------------------------------
  typedef logic [10:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  // one step per clock, two clocks per pixel
  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;
  // sprite index, row in cell, column in cell
  typedef logic [9:0]  sprite_addr_t;

  typedef struct packed {
    logic [5:0] col;
    logic [4:0] row;
  } cell_pos_t;

  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  // host writes raw, output stage reads rgb
  typedef union packed {
    logic [15:0] raw;
    rgb565_t     rgb;
  } pixel_word_u;

  typedef enum logic [1:0] {
    LAYER_BG,
    LAYER_APPLE,
    LAYER_HEAD,
    LAYER_WALL
  } layer_t;

  typedef struct packed {
    logic hs;
    logic vs;
    logic blank_n;
    logic pix_clk;
  } sync_t;

  typedef struct packed {
    cell_pos_t apple;
    cell_pos_t head;
    logic      apple_on;
    logic      head_on;
  } scene_t;

  // ----------------------------------------------------------
  // 640x480 timing, horizontal in clocks
  // ----------------------------------------------------------
  localparam hcount_t H_ACTIVE = 11'd1280;
  localparam hcount_t H_FRONT  = 11'd32;
  localparam hcount_t H_SYNC   = 11'd192;
  localparam hcount_t H_BACK   = 11'd96;
  localparam hcount_t H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  localparam vcount_t V_ACTIVE = 10'd480;
  localparam vcount_t V_FRONT  = 10'd10;
  localparam vcount_t V_SYNC   = 10'd2;
  localparam vcount_t V_BACK   = 10'd33;
  localparam vcount_t V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  // idle sync word, outputs inactive and blanked
  localparam sync_t SYNC_IDLE = '{hs: 1'b1, vs: 1'b1, blank_n: 1'b0, pix_clk: 1'b0};

  // grid of 16x16 cells
  localparam int CELL_PIX     = 16;
  localparam int GRID_COLS    = 40;
  localparam int GRID_ROWS    = 30;
  localparam int SPRITE_WORDS = CELL_PIX * CELL_PIX;
  localparam int NUM_SPRITES  = 3;

  // ----------------------------------------------------------
  // host address map, word addresses
  // ----------------------------------------------------------
  localparam bus_addr_t REG_BACKGROUND = 11'd0;
  localparam bus_addr_t REG_APPLE      = 11'd1;
  localparam bus_addr_t REG_HEAD       = 11'd2;
  localparam bus_addr_t REG_CONTROL    = 11'd3;
  localparam bus_addr_t SPRITE_BASE    = 11'd1024;

  localparam logic [1:0] SPR_APPLE = 2'd0;
  localparam logic [1:0] SPR_HEAD  = 2'd1;
  localparam logic [1:0] SPR_WALL  = 2'd2;

endpackage
